//--- rtl/mem_pkg.sv
package mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH      = 32;
    localparam int WORD_ADDR_WIDTH = 10;
    localparam int BYTE_ADDR_WIDTH = WORD_ADDR_WIDTH + 2;
    localparam int SEL_WIDTH       = 4;
    localparam int BYTE_WIDTH      = 8;
    localparam int HALF_WIDTH      = 16;
    localparam int RAM_DEPTH       = 1 << WORD_ADDR_WIDTH;

    // Grant state codes
    localparam logic [1:0] GRANT_NONE   = 2'd0;
    localparam logic [1:0] GRANT_LOADER = 2'd1;
    localparam logic [1:0] GRANT_DATA   = 2'd2;
    localparam logic [1:0] GRANT_FETCH  = 2'd3;

    typedef enum logic [1:0]
    {
        ACCESS_BYTE = 2'd0,
        ACCESS_HALF = 2'd1,
        ACCESS_WORD = 2'd2
    } access_width_t;

    // One RAM word, seen whole or by lanes
    typedef union packed
    {
        logic [DATA_WIDTH-1:0]                word;
        logic [SEL_WIDTH-1:0][BYTE_WIDTH-1:0] bytes;
        logic [1:0][HALF_WIDTH-1:0]           halves;
    } mem_word_u;

    ////////////////////////////////////////////////////////////////////////////
    // Requester and internal bus structs
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed
    {
        logic                       cyc;
        logic                       stb;
        logic [BYTE_ADDR_WIDTH-1:0] adr;
    } fetch_req_t;

    typedef struct packed
    {
        logic                       cyc;
        logic                       stb;
        logic [BYTE_ADDR_WIDTH-1:0] adr;
        logic [DATA_WIDTH-1:0]      dat;
    } load_req_t;

    typedef struct packed
    {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [BYTE_ADDR_WIDTH-1:0] adr;
        access_width_t              width;
        logic                       sign_extend;
        logic [DATA_WIDTH-1:0]      dat;
    } data_req_t;

    // Word address only
    typedef struct packed
    {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [WORD_ADDR_WIDTH-1:0] adr;
        logic [DATA_WIDTH-1:0]      dat;
        logic [SEL_WIDTH-1:0]       sel;
    } wb_req_t;

    typedef struct packed
    {
        logic                  ack;
        logic [DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

endpackage

//--- rtl/access_align.sv
`timescale 1ns/1ps

module access_align
    import mem_pkg::*;
(
    input  data_req_t data_req,
    input  wb_rsp_t   data_wb_rsp,

    output wb_req_t   data_wb,
    output wb_rsp_t   data_rsp
);

    mem_word_u             wr_word;
    mem_word_u             rd_word;
    logic [SEL_WIDTH-1:0]  sel;
    logic [BYTE_WIDTH-1:0] lane_b;
    logic [HALF_WIDTH-1:0] lane_h;
    logic                  fill_b;
    logic                  fill_h;
    logic [DATA_WIDTH-1:0] load_data;
    logic                  misaligned;

    ////////////////////////////////////////////////////////////////////////////
    // Store side
    ////////////////////////////////////////////////////////////////////////////

    // Replicate the store data so every lane holds it, sel picks the lane
    always_comb
    begin
        case (data_req.width)
            ACCESS_BYTE:
            begin
                wr_word.bytes = {SEL_WIDTH{data_req.dat[BYTE_WIDTH-1:0]}};
                sel           = SEL_WIDTH'(1) << data_req.adr[1:0];
            end
            ACCESS_HALF:
            begin
                wr_word.halves = {2{data_req.dat[HALF_WIDTH-1:0]}};
                sel            = data_req.adr[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                wr_word.word = data_req.dat;
                sel          = '1;
            end
        endcase
    end

    always_comb
    begin
        data_wb.cyc = data_req.cyc;
        data_wb.stb = data_req.stb;
        data_wb.we  = data_req.we;
        data_wb.adr = data_req.adr[BYTE_ADDR_WIDTH-1:2];
        data_wb.dat = wr_word.word;
        data_wb.sel = sel;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load side
    ////////////////////////////////////////////////////////////////////////////

    assign rd_word.word = data_wb_rsp.dat;
    assign lane_b       = rd_word.bytes[data_req.adr[1:0]];
    assign lane_h       = rd_word.halves[data_req.adr[1]];
    assign fill_b       = data_req.sign_extend & lane_b[BYTE_WIDTH-1];
    assign fill_h       = data_req.sign_extend & lane_h[HALF_WIDTH-1];

    always_comb
    begin
        case (data_req.width)
            ACCESS_BYTE: load_data = {{(DATA_WIDTH-BYTE_WIDTH){fill_b}}, lane_b};
            ACCESS_HALF: load_data = {{(DATA_WIDTH-HALF_WIDTH){fill_h}}, lane_h};
            default:     load_data = rd_word.word;
        endcase
    end

    assign data_rsp.ack = data_wb_rsp.ack;
    assign data_rsp.dat = load_data;

    // Requester must keep halfwords and words naturally aligned
    assign misaligned = ((data_req.width == ACCESS_HALF) && data_req.adr[0])
                     || ((data_req.width == ACCESS_WORD) && (data_req.adr[1:0] != 2'b00));

    always_comb
    begin
        if (data_req.stb)
        begin
            align_a: assert final (!misaligned);
        end
    end

endmodule

//--- rtl/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  fetch_req_t fetch_req,
    input  load_req_t  load_req,
    input  wb_req_t    data_wb,
    input  wb_rsp_t    ram_rsp,

    output wb_req_t    ram_bus,
    output wb_rsp_t    fetch_rsp,
    output wb_rsp_t    load_rsp,
    output wb_rsp_t    data_wb_rsp
);

    logic [1:0] grant_q;
    logic [1:0] grant_d;
    wb_req_t    fetch_wb;
    wb_req_t    load_wb;
    logic       fetch_pend;
    logic       load_pend;
    logic       data_pend;

    ////////////////////////////////////////////////////////////////////////////
    // Full-word requests for fetch and loader
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        fetch_wb.cyc = fetch_req.cyc;
        fetch_wb.stb = fetch_req.stb;
        fetch_wb.we  = 1'b0;
        fetch_wb.adr = fetch_req.adr[BYTE_ADDR_WIDTH-1:2];
        fetch_wb.dat = '0;
        fetch_wb.sel = '1;
    end

    always_comb
    begin
        load_wb.cyc = load_req.cyc;
        load_wb.stb = load_req.stb;
        load_wb.we  = 1'b1;
        load_wb.adr = load_req.adr[BYTE_ADDR_WIDTH-1:2];
        load_wb.dat = load_req.dat;
        load_wb.sel = '1;
    end

    assign fetch_pend = fetch_req.cyc & fetch_req.stb;
    assign load_pend  = load_req.cyc & load_req.stb;
    assign data_pend  = data_wb.cyc & data_wb.stb;

    ////////////////////////////////////////////////////////////////////////////
    // Grant state
    ////////////////////////////////////////////////////////////////////////////

    // Loader first, then data, then fetch
    always_comb
    begin
        grant_d = grant_q;
        if (grant_q == GRANT_NONE)
        begin
            if (load_pend)
                grant_d = GRANT_LOADER;
            else if (data_pend)
                grant_d = GRANT_DATA;
            else if (fetch_pend)
                grant_d = GRANT_FETCH;
        end
        else if (ram_rsp.ack)
        begin
            // One idle cycle after every transfer
            grant_d = GRANT_NONE;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            grant_q <= GRANT_NONE;
        else
            grant_q <= grant_d;
    end

    always_comb
    begin
        case (grant_q)
            GRANT_LOADER: ram_bus = load_wb;
            GRANT_DATA:   ram_bus = data_wb;
            GRANT_FETCH:  ram_bus = fetch_wb;
            default:      ram_bus = '0;
        endcase
    end

    // Ack and data go to the granted port only
    always_comb
    begin
        fetch_rsp   = '0;
        load_rsp    = '0;
        data_wb_rsp = '0;
        case (grant_q)
            GRANT_LOADER: load_rsp    = ram_rsp;
            GRANT_DATA:   data_wb_rsp = ram_rsp;
            GRANT_FETCH:  fetch_rsp   = ram_rsp;
            default:      ;
        endcase
    end

    // Each RAM ack reaches exactly one port
    one_ack_a: assert property (@(posedge clk) disable iff (!arst_n)
        ram_rsp.ack |-> $onehot({fetch_rsp.ack, load_rsp.ack, data_wb_rsp.ack}));

    // No port loses the bus in the middle of a transfer
    grant_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        (ram_bus.stb && !ram_rsp.ack) |=> (grant_q == $past(grant_q)) && $stable(ram_bus));

endmodule

//--- rtl/bram_controller.sv
`timescale 1ns/1ps

module bram_controller
    import mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  wb_req_t                    ram_bus,
    input  logic [DATA_WIDTH-1:0]      rdata,

    output wb_rsp_t                    ram_rsp,
    output logic                       en,
    output logic [SEL_WIDTH-1:0]       we_lanes,
    output logic [WORD_ADDR_WIDTH-1:0] addr,
    output logic [DATA_WIDTH-1:0]      wdata
);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_READ_WAIT,
        ST_ACK
    } state_t;

    state_t                state_q;
    state_t                state_d;
    logic                  start;
    logic [DATA_WIDTH-1:0] rdata_q;

    // New access only from idle, so ack cycles never touch the RAM
    assign start = (state_q == ST_IDLE) && ram_bus.cyc && ram_bus.stb;

    assign en       = start;
    assign we_lanes = (start && ram_bus.we) ? ram_bus.sel : '0;
    assign addr     = ram_bus.adr;
    assign wdata    = ram_bus.dat;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (start)
                    state_d = ram_bus.we ? ST_ACK : ST_READ_WAIT;
            end
            ST_READ_WAIT:
                state_d = ST_ACK;
            default:
                state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    // RAM output valid in read-wait
    always_ff @(posedge clk)
    begin
        if (state_q == ST_READ_WAIT)
            rdata_q <= rdata;
    end

    assign ram_rsp.ack = (state_q == ST_ACK);
    assign ram_rsp.dat = rdata_q;

    // Every ack answers a request still on the bus and lasts one cycle
    ack_single_a: assert property (@(posedge clk) disable iff (!arst_n)
        ram_rsp.ack |-> (ram_bus.cyc && ram_bus.stb) ##1 !ram_rsp.ack);

endmodule

//--- rtl/block_ram.sv
`timescale 1ns/1ps

module block_ram
    import mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       en,
    input  logic [SEL_WIDTH-1:0]       we_lanes,
    input  logic [WORD_ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0]      wdata,

    output logic [DATA_WIDTH-1:0]      rdata
);

    mem_word_u mem [RAM_DEPTH];
    mem_word_u wr_word;

    assign wr_word.word = wdata;

    // Byte lanes written independently, read returns the old word
    always_ff @(posedge clk)
    begin
        if (en)
        begin
            for (int i = 0; i < SEL_WIDTH; i++)
            begin
                if (we_lanes[i])
                    mem[addr].bytes[i] <= wr_word.bytes[i];
            end
            rdata <= mem[addr].word;
        end
    end

endmodule

//--- rtl/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  fetch_req_t fetch_req,
    input  load_req_t  load_req,
    input  data_req_t  data_req,

    output wb_rsp_t    fetch_rsp,
    output wb_rsp_t    load_rsp,
    output wb_rsp_t    data_rsp
);

    wb_req_t                    data_wb;
    wb_rsp_t                    data_wb_rsp;
    wb_req_t                    ram_bus;
    wb_rsp_t                    ram_rsp;

    logic                       ram_en;
    logic [SEL_WIDTH-1:0]       ram_we_lanes;
    logic [WORD_ADDR_WIDTH-1:0] ram_addr;
    logic [DATA_WIDTH-1:0]      ram_wdata;
    logic [DATA_WIDTH-1:0]      ram_rdata;

    // Data side lane handling
    access_align u_access_align
    (
        .data_req    (data_req),
        .data_wb_rsp (data_wb_rsp),
        .data_wb     (data_wb),
        .data_rsp    (data_rsp)
    );

    port_arbiter u_port_arbiter
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_req   (fetch_req),
        .load_req    (load_req),
        .data_wb     (data_wb),
        .ram_rsp     (ram_rsp),
        .ram_bus     (ram_bus),
        .fetch_rsp   (fetch_rsp),
        .load_rsp    (load_rsp),
        .data_wb_rsp (data_wb_rsp)
    );

    bram_controller u_bram_controller
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .ram_bus  (ram_bus),
        .rdata    (ram_rdata),
        .ram_rsp  (ram_rsp),
        .en       (ram_en),
        .we_lanes (ram_we_lanes),
        .addr     (ram_addr),
        .wdata    (ram_wdata)
    );

    block_ram u_block_ram
    (
        .clk      (clk),
        .en       (ram_en),
        .we_lanes (ram_we_lanes),
        .addr     (ram_addr),
        .wdata    (ram_wdata),
        .rdata    (ram_rdata)
    );

endmodule

//--- testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem
    import mem_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int ACK_LIMIT   = 20;
    localparam int N_RANDOM    = 32;
    localparam int N_TRANSFERS = 2 * N_RANDOM + 30;
    localparam int TIMEOUT_NS  = N_TRANSFERS * 10 * CLK_PERIOD + 100 * CLK_PERIOD;

    logic                  clk;
    logic                  arst_n;
    fetch_req_t            fetch_req;
    load_req_t             load_req;
    data_req_t             data_req;
    wb_rsp_t               fetch_rsp;
    wb_rsp_t               load_rsp;
    wb_rsp_t               data_rsp;
    integer                seed;
    logic [11:0]           ack_seq;
    logic [BYTE_WIDTH-1:0] model_mem [RAM_DEPTH*SEL_WIDTH];

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_subsystem u_mem_subsystem
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch_req (fetch_req),
        .load_req  (load_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .load_rsp  (load_rsp),
        .data_rsp  (data_rsp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checking and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                               input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s expected %08h actual %08h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic report_timeout(input string port);
        $display("The %s port never acknowledged its transfer", port);
        $display("ERRORS FOUND");
        $fatal(1, "Acknowledge timeout");
    endtask

    function automatic logic [DATA_WIDTH-1:0] model_word(input logic [BYTE_ADDR_WIDTH-1:0] adr);
        int base;
        base = {adr[BYTE_ADDR_WIDTH-1:2], 2'b00};
        return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
    endfunction

    task automatic model_store(input logic [BYTE_ADDR_WIDTH-1:0] adr, input access_width_t width,
                               input logic [DATA_WIDTH-1:0] dat);
        int n;
        n = (width == ACCESS_BYTE) ? 1 : ((width == ACCESS_HALF) ? 2 : 4);
        for (int i = 0; i < n; i++)
            model_mem[adr + i] = dat[8*i +: 8];
    endtask

    // Lane pick plus extension by the lane's top bit
    function automatic logic [DATA_WIDTH-1:0] model_load(input logic [BYTE_ADDR_WIDTH-1:0] adr,
                                                         input access_width_t width,
                                                         input logic sign);
        logic [7:0]  b;
        logic [15:0] h;
        b = model_mem[adr];
        h = {model_mem[adr + 1], model_mem[adr]};
        case (width)
            ACCESS_BYTE: return (sign && b[7]) ? {24'hffffff, b} : {24'h0, b};
            ACCESS_HALF: return (sign && h[15]) ? {16'hffff, h} : {16'h0, h};
            default:     return model_word(adr);
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fetch_read(input logic [BYTE_ADDR_WIDTH-1:0] adr,
                              output logic [DATA_WIDTH-1:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        fetch_req <= '{cyc: 1'b1, stb: 1'b1, adr: adr};
        @(negedge clk);
        while (!fetch_rsp.ack)
        begin
            waited++;
            if (waited > ACK_LIMIT)
                report_timeout("fetch");
            @(negedge clk);
        end
        rdata   = fetch_rsp.dat;
        ack_seq = {ack_seq[7:0], 4'h3};
        @(posedge clk);
        fetch_req <= '0;
    endtask

    task automatic load_write(input logic [BYTE_ADDR_WIDTH-1:0] adr,
                              input logic [DATA_WIDTH-1:0] dat);
        int waited;
        waited = 0;
        @(posedge clk);
        load_req <= '{cyc: 1'b1, stb: 1'b1, adr: adr, dat: dat};
        @(negedge clk);
        while (!load_rsp.ack)
        begin
            waited++;
            if (waited > ACK_LIMIT)
                report_timeout("loader");
            @(negedge clk);
        end
        ack_seq = {ack_seq[7:0], 4'h1};
        model_store(adr, ACCESS_WORD, dat);
        @(posedge clk);
        load_req <= '0;
    endtask

    task automatic data_access(input logic we, input logic [BYTE_ADDR_WIDTH-1:0] adr,
                               input access_width_t width, input logic sign,
                               input logic [DATA_WIDTH-1:0] dat,
                               output logic [DATA_WIDTH-1:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        data_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, width: width,
                      sign_extend: sign, dat: dat};
        @(negedge clk);
        while (!data_rsp.ack)
        begin
            waited++;
            if (waited > ACK_LIMIT)
                report_timeout("data");
            @(negedge clk);
        end
        rdata   = data_rsp.dat;
        ack_seq = {ack_seq[7:0], 4'h2};
        if (we)
            model_store(adr, width, dat);
        @(posedge clk);
        data_req <= '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_idle();
        repeat (6)
        begin
            @(negedge clk);
            check_value("reset_idle", '0, {fetch_rsp.ack, load_rsp.ack, data_rsp.ack});
        end
    endtask

    task automatic test_load_fetch();
        logic [BYTE_ADDR_WIDTH-1:0] addrs [N_RANDOM];
        logic [DATA_WIDTH-1:0]      wdata;
        logic [DATA_WIDTH-1:0]      rdata;
        for (int i = 0; i < N_RANDOM; i++)
        begin
            addrs[i]      = $random(seed);
            addrs[i][1:0] = 2'b00;
            wdata         = $random(seed);
            load_write(addrs[i], wdata);
        end
        for (int i = 0; i < N_RANDOM; i++)
        begin
            fetch_read(addrs[i], rdata);
            check_value("load_fetch", model_word(addrs[i]), rdata);
        end
    endtask

    task automatic test_lane_stores();
        logic [DATA_WIDTH-1:0] rdata;
        load_write(12'h100, 32'h1122_3344);
        load_write(12'h104, 32'h5566_7788);
        data_access(1'b1, 12'h101, ACCESS_BYTE, 1'b0, 32'h0000_00a5, rdata);
        data_access(1'b1, 12'h102, ACCESS_HALF, 1'b0, 32'h0000_b6c7, rdata);
        data_access(1'b0, 12'h100, ACCESS_WORD, 1'b0, '0, rdata);
        check_value("lane_stores_data", model_word(12'h100), rdata);
        fetch_read(12'h100, rdata);
        check_value("lane_stores_fetch", model_word(12'h100), rdata);
        // Neighbour word must be untouched
        fetch_read(12'h104, rdata);
        check_value("lane_stores_neighbour", model_word(12'h104), rdata);
    endtask

    task automatic test_lane_loads();
        logic [DATA_WIDTH-1:0] rdata;
        load_write(12'h200, 32'h80f1_7f82);
        for (int s = 0; s < 2; s++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                data_access(1'b0, 12'h200 + off, ACCESS_BYTE, s[0], '0, rdata);
                check_value("byte_load", model_load(12'h200 + off, ACCESS_BYTE, s[0]), rdata);
            end
            for (int off = 0; off < 4; off += 2)
            begin
                data_access(1'b0, 12'h200 + off, ACCESS_HALF, s[0], '0, rdata);
                check_value("half_load", model_load(12'h200 + off, ACCESS_HALF, s[0]), rdata);
            end
        end
    endtask

    task automatic test_contention();
        logic [DATA_WIDTH-1:0] wdata;
        logic [DATA_WIDTH-1:0] exp_data;
        logic [DATA_WIDTH-1:0] data_val;
        logic [DATA_WIDTH-1:0] fetch_val;
        wdata    = $random(seed);
        exp_data = model_load(12'h203, ACCESS_BYTE, 1'b1);
        ack_seq  = '0;
        fork
            load_write(12'h300, wdata);
            data_access(1'b0, 12'h203, ACCESS_BYTE, 1'b1, '0, data_val);
            fetch_read(12'h300, fetch_val);
        join
        check_value("contention_order", 32'h123, ack_seq);
        check_value("contention_data", exp_data, data_val);
        check_value("contention_fetch", wdata, fetch_val);
    endtask

    initial
    begin
        seed      = 32'h4c7b365e;
        clk       = 1'b0;
        arst_n    = 1'b0;
        fetch_req = '0;
        load_req  = '0;
        data_req  = '0;
        ack_seq   = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        test_reset_idle();
        test_load_fetch();
        test_lane_stores();
        test_lane_loads();
        test_contention();
        $display("NO ERRORS");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $fatal(1, "Simulation timeout");
    end

endmodule

//--- all.f
rtl/mem_pkg.sv
rtl/access_align.sv
rtl/port_arbiter.sv
rtl/bram_controller.sv
rtl/block_ram.sv
rtl/mem_subsystem.sv
testbench/tb_mem_subsystem.sv
